// File: include/pce_cart_config.svh
`ifndef PCE_CART_CONFIG_SVH
`define PCE_CART_CONFIG_SVH

// console side byte address width
`define PCE_ROM_ADDR_W 22
// storage word address width, 8K words of 16 bits
`define PCE_MEM_ADDR_W 13
// storage word width
`define PCE_WORD_W 16
// download byte counter width, size in 4 KB pages is the top 12 bits
`define PCE_BYTE_CNT_W 24

// copier header length, also the test bit in the loaded length
`define PCE_HEADER_BYTES 512

// populous signature windows, low one for headerless images
`define PCE_POP_BASE_LO 24'h001F20
`define PCE_POP_BASE_HI 24'h002120

// signature words at window offsets 6, 8, 10 and 12
`define PCE_POP_SIG0 16'h4F50
`define PCE_POP_SIG1 16'h5550
`define PCE_POP_SIG2 16'h4F4C
`define PCE_POP_SIG3 16'h5355

`endif

// File: verilog/pce_cart_pkg.sv
`default_nettype none

`include "pce_cart_config.svh"

package pce_cart_pkg;

  // one storage word
  typedef logic [`PCE_WORD_W-1:0] mem_word_t;

  // word address into cartridge storage
  typedef logic [`PCE_MEM_ADDR_W-1:0] mem_addr_t;

  // byte address as seen by the console
  typedef logic [`PCE_ROM_ADDR_W-1:0] rom_addr_t;

  // what the loader learned about the image
  typedef struct packed {
    logic        header_present;
    logic        populous;
    // loaded bytes / 4096
    logic [11:0] size_pages;
  } cart_info_t;

endpackage

`default_nettype wire

// File: verilog/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// one client's path to the shared cartridge storage
// four phase: req up, ack up, req down, ack down
interface mem_bus_if import pce_cart_pkg::*; ();

  logic      req;
  logic      ack;
  // high for a write, low for a read
  logic      we;
  mem_addr_t addr;
  mem_word_t wdata;
  // valid while ack is high on a read
  mem_word_t rdata;

  // the loader or the fetch unit
  modport client (
    output req,
    output we,
    output addr,
    output wdata,
    input  ack,
    input  rdata
  );

  // the side that owns the storage
  modport arbiter (
    input  req,
    input  we,
    input  addr,
    input  wdata,
    output ack,
    output rdata
  );

endinterface

`default_nettype wire

// File: verilog/cart_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pce_cart_config.svh"

module cart_loader import pce_cart_pkg::*; (
  input  logic       clk_sys_42_95,
  input  logic       rst_n,
  input  logic       cart_download,
  input  logic       ioctl_wr,
  input  mem_word_t  ioctl_dout,
  input  logic       byte_swap,
  output logic       ioctl_wait,
  output cart_info_t info,
  mem_bus_if.client  mem
);

  typedef enum logic [1:0] {ld_idle, ld_req, ld_drop} ld_state_t;

  localparam logic [`PCE_BYTE_CNT_W-1:0] pop_base_lo = `PCE_POP_BASE_LO;
  localparam logic [`PCE_BYTE_CNT_W-1:0] pop_base_hi = `PCE_POP_BASE_HI;

  ld_state_t                   state;
  logic                        dl_q;
  logic                        wr_q;
  logic [`PCE_BYTE_CNT_W-1:0]  byte_addr;
  // one flag per signature window, cleared on any mismatch
  logic [1:0]                  pop_ok;
  mem_word_t                   wdata_q;
  mem_word_t                   host_word;
  mem_word_t                   sig_expect;
  logic                        sig_slot;
  logic                        sig_window;
  logic                        dl_rise;
  logic                        wr_rise;

  // mirror bit order inside each byte
  function automatic mem_word_t bit_rev_bytes(input mem_word_t w);
    mem_word_t r;
    for (int i = 0; i < 8; i++) begin
      r[i]     = w[7-i];
      r[8+i]   = w[15-i];
    end
    return r;
  endfunction

  assign dl_rise   = cart_download & ~dl_q;
  // strobes only count during a download
  assign wr_rise   = ioctl_wr & ~wr_q & cart_download;
  assign host_word = byte_swap ? bit_rev_bytes(ioctl_dout) : ioctl_dout;

  // inside one of the two 16 byte windows
  assign sig_window = (byte_addr[`PCE_BYTE_CNT_W-1:4] == pop_base_lo[`PCE_BYTE_CNT_W-1:4]) ||
                      (byte_addr[`PCE_BYTE_CNT_W-1:4] == pop_base_hi[`PCE_BYTE_CNT_W-1:4]);

  // expected word per offset in the window
  always_comb begin
    sig_slot   = 1'b1;
    sig_expect = `PCE_POP_SIG0;
    case (byte_addr[3:0])
      4'd6:  sig_expect = `PCE_POP_SIG0;
      4'd8:  sig_expect = `PCE_POP_SIG1;
      4'd10: sig_expect = `PCE_POP_SIG2;
      4'd12: sig_expect = `PCE_POP_SIG3;
      default: sig_slot = 1'b0;
    endcase
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (!rst_n) begin
      state      <= ld_idle;
      dl_q       <= 1'b0;
      wr_q       <= 1'b0;
      mem.req    <= 1'b0;
      ioctl_wait <= 1'b0;
      byte_addr  <= '0;
      pop_ok     <= 2'b11;
    end else begin
      dl_q <= cart_download;
      wr_q <= ioctl_wr;
      case (state)
        ld_idle: begin
          if (wr_rise) begin
            mem.req    <= 1'b1;
            // back-pressure until the write is fully done
            ioctl_wait <= 1'b1;
            state      <= ld_req;
            // address bit 13 picks the window
            if (sig_window && sig_slot && host_word != sig_expect)
              pop_ok[byte_addr[13]] <= 1'b0;
          end
        end
        ld_req: begin
          if (mem.ack) begin
            mem.req <= 1'b0;
            state   <= ld_drop;
          end
        end
        ld_drop: begin
          // wait for ack to fall, then next word
          if (!mem.ack) begin
            ioctl_wait <= 1'b0;
            byte_addr  <= byte_addr + `PCE_BYTE_CNT_W'd2;
            state      <= ld_idle;
          end
        end
        default: state <= ld_idle;
      endcase
      // new download restarts everything
      if (dl_rise) begin
        byte_addr <= '0;
        pop_ok    <= 2'b11;
      end
    end
  end

  // captured host word
  always_ff @(posedge clk_sys_42_95) begin
    if (state == ld_idle && wr_rise)
      wdata_q <= host_word;
  end

  assign mem.we    = 1'b1;
  assign mem.addr  = byte_addr[`PCE_MEM_ADDR_W:1];
  assign mem.wdata = wdata_q;

  // bit 9 set means a 512 byte copier header came along
  assign info = '{header_present: byte_addr[9],
                  populous:       pop_ok[byte_addr[9]],
                  size_pages:     byte_addr[`PCE_BYTE_CNT_W-1:12]};

  // a new request only once the previous ack has dropped
  req_after_ack_low: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    $rose(mem.req) |-> !mem.ack)
    else $error("loader raised req while ack still high");

endmodule

`default_nettype wire

// File: verilog/rom_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "pce_cart_config.svh"

module rom_fetch import pce_cart_pkg::*; (
  input  logic       clk_sys_42_95,
  input  logic       rst_n,
  input  logic       rom_rd,
  input  rom_addr_t  rom_addr,
  input  cart_info_t info,
  output logic       rom_rdy,
  output logic [7:0] rom_data,
  mem_bus_if.client  mem
);

  typedef enum logic [1:0] {rf_idle, rf_req, rf_drop, rf_rdy} rf_state_t;

  rf_state_t state;
  rom_addr_t eff_addr;
  mem_addr_t word_addr_q;
  logic      odd_q;

  // skip the copier header when the image has one
  assign eff_addr = rom_addr + (info.header_present ? rom_addr_t'(`PCE_HEADER_BYTES) : '0);

  always_ff @(posedge clk_sys_42_95) begin
    if (!rst_n) begin
      state   <= rf_idle;
      mem.req <= 1'b0;
      rom_rdy <= 1'b0;
    end else begin
      case (state)
        rf_idle: begin
          if (rom_rd) begin
            mem.req <= 1'b1;
            state   <= rf_req;
          end
        end
        rf_req: begin
          // data is on rdata while ack is up
          if (mem.ack) begin
            mem.req <= 1'b0;
            state   <= rf_drop;
          end
        end
        rf_drop: begin
          // memory side closed before the console sees rdy
          if (!mem.ack) begin
            rom_rdy <= 1'b1;
            state   <= rf_rdy;
          end
        end
        rf_rdy: begin
          if (!rom_rd) begin
            rom_rdy <= 1'b0;
            state   <= rf_idle;
          end
        end
        default: state <= rf_idle;
      endcase
    end
  end

  // word address and byte lane of the request
  always_ff @(posedge clk_sys_42_95) begin
    if (state == rf_idle && rom_rd) begin
      word_addr_q <= eff_addr[`PCE_MEM_ADDR_W:1];
      odd_q       <= eff_addr[0];
    end
  end

  // low byte for even, high byte for odd
  always_ff @(posedge clk_sys_42_95) begin
    if (state == rf_req && mem.ack)
      rom_data <= odd_q ? mem.rdata[15:8] : mem.rdata[7:0];
  end

  // read only client
  assign mem.we    = 1'b0;
  assign mem.addr  = word_addr_q;
  assign mem.wdata = '0;

  // console side four phase
  rdy_held_until_rd_low: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    rom_rdy && rom_rd |=> rom_rdy)
    else $error("rom_rdy dropped before rom_rd fell");

endmodule

`default_nettype wire

// File: verilog/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import pce_cart_pkg::*; (
  input  logic        clk_sys_42_95,
  input  logic        rst_n,
  mem_bus_if.arbiter  ldr,
  mem_bus_if.arbiter  fet,
  output logic        ram_en,
  output logic        ram_we,
  output mem_addr_t   ram_addr,
  output mem_word_t   ram_wdata,
  input  mem_word_t   ram_rdata
);

  typedef enum logic [1:0] {arb_idle, arb_access, arb_ack} arb_state_t;

  arb_state_t state;
  // 1 loader owns storage, 0 fetch owns it
  logic       gnt_ldr;
  logic       ldr_ack;
  logic       fet_ack;
  logic       gnt_req;

  // request of whoever holds the grant
  assign gnt_req = gnt_ldr ? ldr.req : fet.req;

  always_ff @(posedge clk_sys_42_95) begin
    if (!rst_n) begin
      state   <= arb_idle;
      gnt_ldr <= 1'b0;
      ldr_ack <= 1'b0;
      fet_ack <= 1'b0;
    end else begin
      case (state)
        arb_idle: begin
          // loader first
          if (ldr.req) begin
            gnt_ldr <= 1'b1;
            state   <= arb_access;
          end else if (fet.req) begin
            gnt_ldr <= 1'b0;
            state   <= arb_access;
          end
        end
        arb_access: begin
          // storage enabled this cycle, data out next
          ldr_ack <= gnt_ldr;
          fet_ack <= ~gnt_ldr;
          state   <= arb_ack;
        end
        arb_ack: begin
          // hold until the client lets go
          if (!gnt_req) begin
            ldr_ack <= 1'b0;
            fet_ack <= 1'b0;
            state   <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // storage port follows the grant
  assign ram_en    = (state == arb_access);
  assign ram_we    = gnt_ldr ? ldr.we : fet.we;
  assign ram_addr  = gnt_ldr ? ldr.addr : fet.addr;
  assign ram_wdata = gnt_ldr ? ldr.wdata : fet.wdata;

  assign ldr.ack   = ldr_ack;
  assign fet.ack   = fet_ack;
  // read data stays put until the next enable
  assign ldr.rdata = ram_rdata;
  assign fet.rdata = ram_rdata;

  one_ack_at_a_time: assert property (@(posedge clk_sys_42_95) disable iff (!rst_n)
    !(ldr.ack && fet.ack))
    else $error("both memory clients acknowledged together");

endmodule

`default_nettype wire

// File: verilog/cart_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cart_ram import pce_cart_pkg::*; (
  input  logic      clk_sys_42_95,
  input  logic      en,
  input  logic      we,
  input  mem_addr_t addr,
  input  mem_word_t wdata,
  output mem_word_t rdata
);

  // full address range of the storage
  localparam int depth = 1 << $bits(mem_addr_t);

  mem_word_t mem [depth];

  // single port, read data one cycle after en
  always_ff @(posedge clk_sys_42_95) begin
    if (en) begin
      if (we)
        mem[addr] <= wdata;
      // old contents on a write cycle
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: verilog/pad_mux.sv
`timescale 1ns/1ps
`default_nettype none

module pad_mux (
  input  logic       clk_sys_42_95,
  input  logic       rst_n,
  input  logic       button_a,
  input  logic       button_b,
  input  logic       button_select,
  input  logic       button_start,
  input  logic       dpad_up,
  input  logic       dpad_down,
  input  logic       dpad_left,
  input  logic       dpad_right,
  input  logic       pad_sel,
  input  logic       pad_clr,
  input  logic       multitap_en,
  output logic [3:0] pad_nibble
);

  // multitap port, saturates at 7
  logic [2:0] port_q;
  logic [2:0] port_next;
  logic       sel_q;
  logic       sel_rise;
  logic [3:0] nibble_next;

  assign sel_rise = pad_sel & ~sel_q;

  // clear wins over select
  always_comb begin
    port_next = port_q;
    if (pad_clr)
      port_next = 3'd0;
    else if (sel_rise && multitap_en && port_q != 3'd7)
      port_next = port_q + 3'd1;
  end

  // nibble from the port we are moving to
  always_comb begin
    if (pad_clr)
      nibble_next = 4'h0;
    else if (port_next != 3'd0)
      // nothing plugged beyond port 0
      nibble_next = 4'hF;
    else if (pad_sel)
      // directions, up in bit 0
      nibble_next = ~{dpad_left, dpad_down, dpad_right, dpad_up};
    else
      // buttons, a in bit 0
      nibble_next = ~{button_start, button_select, button_b, button_a};
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (!rst_n) begin
      port_q     <= 3'd0;
      sel_q      <= 1'b0;
      pad_nibble <= 4'hF;
    end else begin
      port_q     <= port_next;
      sel_q      <= pad_sel;
      // registered, valid one cycle after inputs
      pad_nibble <= nibble_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pce_cart_top.sv
`timescale 1ns/1ps
`default_nettype none

module pce_cart_top import pce_cart_pkg::*; (
  input  logic        clk_sys_42_95,
  input  logic        rst_n,
  // host download
  input  logic        cart_download,
  input  logic        ioctl_wr,
  input  mem_word_t   ioctl_dout,
  input  logic        byte_swap,
  output logic        ioctl_wait,
  // console rom port
  input  logic        rom_rd,
  input  rom_addr_t   rom_addr,
  output logic        rom_rdy,
  output logic [7:0]  rom_data,
  output logic        rom_populous,
  output logic [11:0] rom_size,
  // joypad
  input  logic        button_a,
  input  logic        button_b,
  input  logic        button_select,
  input  logic        button_start,
  input  logic        dpad_up,
  input  logic        dpad_down,
  input  logic        dpad_left,
  input  logic        dpad_right,
  input  logic        pad_sel,
  input  logic        pad_clr,
  input  logic        multitap_en,
  output logic [3:0]  pad_nibble
);

  cart_info_t info;
  logic       ram_en;
  logic       ram_we;
  mem_addr_t  ram_addr;
  mem_word_t  ram_wdata;
  mem_word_t  ram_rdata;

  // one bus per storage client
  mem_bus_if ldr_bus ();
  mem_bus_if fet_bus ();

  cart_loader u_cart_loader (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .byte_swap     (byte_swap),
    .ioctl_wait    (ioctl_wait),
    .info          (info),
    .mem           (ldr_bus.client)
  );

  rom_fetch u_rom_fetch (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .rom_rd        (rom_rd),
    .rom_addr      (rom_addr),
    .info          (info),
    .rom_rdy       (rom_rdy),
    .rom_data      (rom_data),
    .mem           (fet_bus.client)
  );

  mem_arbiter u_mem_arbiter (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .ldr           (ldr_bus.arbiter),
    .fet           (fet_bus.arbiter),
    .ram_en        (ram_en),
    .ram_we        (ram_we),
    .ram_addr      (ram_addr),
    .ram_wdata     (ram_wdata),
    .ram_rdata     (ram_rdata)
  );

  cart_ram u_cart_ram (
    .clk_sys_42_95 (clk_sys_42_95),
    .en            (ram_en),
    .we            (ram_we),
    .addr          (ram_addr),
    .wdata         (ram_wdata),
    .rdata         (ram_rdata)
  );

  pad_mux u_pad_mux (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .button_a      (button_a),
    .button_b      (button_b),
    .button_select (button_select),
    .button_start  (button_start),
    .dpad_up       (dpad_up),
    .dpad_down     (dpad_down),
    .dpad_left     (dpad_left),
    .dpad_right    (dpad_right),
    .pad_sel       (pad_sel),
    .pad_clr       (pad_clr),
    .multitap_en   (multitap_en),
    .pad_nibble    (pad_nibble)
  );

  // cartridge facts for the console
  assign rom_populous = info.populous;
  assign rom_size     = info.size_pages;

endmodule

`default_nettype wire

// File: verification/tb_pce_cart.sv
`timescale 1ns/1ps
`default_nettype none

`include "pce_cart_config.svh"

module tb_pce_cart;

  // one download scenario and what the console should see afterwards
  typedef struct packed {
    logic [15:0] len;
    logic        swap;
    // 0 none, 1 full signature, 2 signature with one bad word
    logic [1:0]  patch;
    logic [15:0] rd_base;
    logic [15:0] n_reads;
    logic [11:0] exp_size;
    logic        exp_pop;
  } scen_t;

  // one pad step with its nibble expected a cycle later
  typedef struct packed {
    logic       clr;
    logic       mt;
    logic       sel;
    // {left, down, right, up}
    logic [3:0] dir;
    // {start, select, b, a}
    logic [3:0] btn;
    logic [3:0] exp_nib;
  } pad_row_t;

  localparam int n_scen     = 5;
  localparam int n_pad      = 24;
  localparam int wait_limit = 200;
  localparam int img_bytes  = 1 << 14;

  logic                         clk_sys_42_95;
  logic                         rst_n;
  logic                         cart_download;
  logic                         ioctl_wr;
  logic [15:0]                  ioctl_dout;
  logic                         byte_swap;
  logic                         ioctl_wait;
  logic                         rom_rd;
  logic [`PCE_ROM_ADDR_W-1:0]   rom_addr;
  logic                         rom_rdy;
  logic [7:0]                   rom_data;
  logic                         rom_populous;
  logic [11:0]                  rom_size;
  logic                         button_a;
  logic                         button_b;
  logic                         button_select;
  logic                         button_start;
  logic                         dpad_up;
  logic                         dpad_down;
  logic                         dpad_left;
  logic                         dpad_right;
  logic                         pad_sel;
  logic                         pad_clr;
  logic                         multitap_en;
  logic [3:0]                   pad_nibble;

  scen_t      scen [n_scen];
  pad_row_t   pad_rows [n_pad];
  // byte image as the console should see it
  logic [7:0] img [img_bytes];
  logic [31:0] lfsr;

  pce_cart_top u_pce_cart_top (
    .clk_sys_42_95 (clk_sys_42_95),
    .rst_n         (rst_n),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .byte_swap     (byte_swap),
    .ioctl_wait    (ioctl_wait),
    .rom_rd        (rom_rd),
    .rom_addr      (rom_addr),
    .rom_rdy       (rom_rdy),
    .rom_data      (rom_data),
    .rom_populous  (rom_populous),
    .rom_size      (rom_size),
    .button_a      (button_a),
    .button_b      (button_b),
    .button_select (button_select),
    .button_start  (button_start),
    .dpad_up       (dpad_up),
    .dpad_down     (dpad_down),
    .dpad_left     (dpad_left),
    .dpad_right    (dpad_right),
    .pad_sel       (pad_sel),
    .pad_clr       (pad_clr),
    .multitap_en   (multitap_en),
    .pad_nibble    (pad_nibble)
  );

  // 100 ns period
  always #50 clk_sys_42_95 = ~clk_sys_42_95;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] reverse_byte(input logic [7:0] b);
    return {b[0], b[1], b[2], b[3], b[4], b[5], b[6], b[7]};
  endfunction

  // signature words land at low window offsets 6..12
  function automatic logic [15:0] patch_word(input int a, input logic [15:0] w,
                                             input logic bad);
    int off;
    logic [15:0] r;
    off = a - int'(`PCE_POP_BASE_LO);
    case (off)
      6:  r = `PCE_POP_SIG0;
      8:  r = `PCE_POP_SIG1;
      // one flipped bit spoils the signature
      10: r = bad ? (`PCE_POP_SIG2 ^ 16'h0100) : `PCE_POP_SIG2;
      12: r = `PCE_POP_SIG3;
      default: r = w;
    endcase
    return r;
  endfunction

  // drive point just after the rising edge
  task automatic tick();
    @(posedge clk_sys_42_95);
    #1;
  endtask

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("ERROR %0t: %s is %0h, expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // one lfsr step per bit of the word
  task automatic next_word(output logic [15:0] w);
    int i;
    w = '0;
    for (i = 0; i < 16; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[14:0], lfsr[0]};
    end
  endtask

  task automatic wait_ioctl_wait(input logic level);
    int n;
    n = 0;
    while (ioctl_wait !== level && n < wait_limit) begin
      tick();
      n++;
    end
    if (ioctl_wait !== level) begin
      $display("timeout: ioctl_wait did not go to %0d", level);
      abort_run();
    end
  endtask

  task automatic wait_rom_rdy(input logic level);
    int n;
    n = 0;
    while (rom_rdy !== level && n < wait_limit) begin
      tick();
      n++;
    end
    if (rom_rdy !== level) begin
      $display("timeout: rom_rdy did not go to %0d", level);
      abort_run();
    end
  endtask

  // one strobe held off by ioctl_wait
  task automatic host_write(input logic [15:0] w);
    ioctl_dout = w;
    ioctl_wr   = 1'b1;
    wait_ioctl_wait(1'b1);
    ioctl_wr   = 1'b0;
    wait_ioctl_wait(1'b0);
  endtask

  task automatic console_read(input int a, output logic [7:0] d);
    rom_addr = `PCE_ROM_ADDR_W'(a);
    rom_rd   = 1'b1;
    wait_rom_rdy(1'b1);
    d        = rom_data;
    rom_rd   = 1'b0;
    wait_rom_rdy(1'b0);
  endtask

  task automatic download(input scen_t s);
    logic [15:0] w;
    int a;
    byte_swap     = s.swap;
    cart_download = 1'b1;
    tick();
    tick();
    for (a = 0; a < int'(s.len); a += 2) begin
      next_word(w);
      if (s.patch != 2'd0)
        w = patch_word(a, w, s.patch == 2'd2);
      // low byte at the even address
      img[14'(a)]     = s.swap ? reverse_byte(w[7:0]) : w[7:0];
      img[14'(a + 1)] = s.swap ? reverse_byte(w[15:8]) : w[15:8];
      host_write(w);
    end
    cart_download = 1'b0;
    tick();
  endtask

  task automatic check_scenario(input scen_t s);
    logic [7:0] d;
    int hdr_off;
    int a;
    // a copier header leaves 512 bytes over a multiple of 1024
    hdr_off = (int'(s.len) % 1024 == 512) ? `PCE_HEADER_BYTES : 0;
    for (a = int'(s.rd_base); a < int'(s.rd_base) + int'(s.n_reads); a++) begin
      console_read(a, d);
      check_value("rom_data", 32'(d), 32'(img[14'(a + hdr_off)]));
    end
    check_value("rom_size", 32'(rom_size), 32'(s.exp_size));
    check_value("rom_populous", 32'(rom_populous), 32'(s.exp_pop));
  endtask

  task automatic run_pad_table();
    int i;
    for (i = 0; i < n_pad; i++) begin
      pad_clr     = pad_rows[i].clr;
      multitap_en = pad_rows[i].mt;
      pad_sel     = pad_rows[i].sel;
      {dpad_left, dpad_down, dpad_right, dpad_up}             = pad_rows[i].dir;
      {button_start, button_select, button_b, button_a}       = pad_rows[i].btn;
      tick();
      check_value("pad_nibble", 32'(pad_nibble), 32'(pad_rows[i].exp_nib));
    end
  endtask

  task automatic fill_tables();
    int i;
    // len, swap, patch, rd_base, n_reads, size, populous
    scen[0] = '{16'd4096, 1'b0, 2'd0, 16'h0000, 16'd4096, 12'd1, 1'b1};
    scen[1] = '{16'd4096, 1'b1, 2'd0, 16'h0000, 16'd4096, 12'd1, 1'b1};
    // header image where console 0 maps to image byte 512
    scen[2] = '{16'd4608, 1'b0, 2'd0, 16'h0000, 16'd4096, 12'd1, 1'b1};
    scen[3] = '{16'd8192, 1'b0, 2'd1, 16'h1F20, 16'd16, 12'd2, 1'b1};
    scen[4] = '{16'd8192, 1'b0, 2'd2, 16'h1F20, 16'd16, 12'd2, 1'b0};
    // clr, mt, sel, dir, btn, nibble
    pad_rows[0]  = '{1'b1, 1'b0, 1'b0, 4'h0, 4'h0, 4'h0};
    pad_rows[1]  = '{1'b0, 1'b0, 1'b0, 4'h0, 4'h5, 4'hA};
    // sel rise without multitap stays on port 0
    pad_rows[2]  = '{1'b0, 1'b0, 1'b1, 4'h3, 4'h0, 4'hC};
    pad_rows[3]  = '{1'b0, 1'b0, 1'b0, 4'h0, 4'h8, 4'h7};
    pad_rows[4]  = '{1'b0, 1'b0, 1'b1, 4'hF, 4'h0, 4'h0};
    pad_rows[5]  = '{1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 4'hF};
    pad_rows[6]  = '{1'b0, 1'b1, 1'b1, 4'hF, 4'h0, 4'hF};
    pad_rows[7]  = '{1'b0, 1'b1, 1'b0, 4'h0, 4'hF, 4'hF};
    // ports 2 to 7 and then held at 7
    // everything pressed so port 0 would show 0
    for (i = 8; i <= 20; i++)
      pad_rows[i] = '{1'b0, 1'b1, (i % 2 == 0), 4'hF, 4'hF, 4'hF};
    pad_rows[21] = '{1'b1, 1'b1, 1'b1, 4'h0, 4'h0, 4'h0};
    // sel already high so no new port
    pad_rows[22] = '{1'b0, 1'b1, 1'b1, 4'h1, 4'h0, 4'hE};
    pad_rows[23] = '{1'b0, 1'b1, 1'b0, 4'h0, 4'h2, 4'hD};
  endtask

  initial begin
    int i;
    clk_sys_42_95 = 1'b0;
    rst_n         = 1'b0;
    cart_download = 1'b0;
    ioctl_wr      = 1'b0;
    ioctl_dout    = '0;
    byte_swap     = 1'b0;
    rom_rd        = 1'b0;
    rom_addr      = '0;
    {button_start, button_select, button_b, button_a} = 4'h0;
    {dpad_left, dpad_down, dpad_right, dpad_up}       = 4'h0;
    pad_sel       = 1'b0;
    pad_clr       = 1'b0;
    multitap_en   = 1'b0;
    lfsr          = 32'h769e_8369;
    fill_tables();
    repeat (8) @(posedge clk_sys_42_95);
    #1;
    // reset values before release
    check_value("ioctl_wait in reset", 32'(ioctl_wait), 32'h0);
    check_value("rom_rdy in reset", 32'(rom_rdy), 32'h0);
    check_value("pad_nibble in reset", 32'(pad_nibble), 32'hF);
    rst_n = 1'b1;
    tick();
    for (i = 0; i < n_scen; i++) begin
      download(scen[i]);
      check_scenario(scen[i]);
    end
    run_pad_table();
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: pce_cart_top.f
+incdir+include
verilog/pce_cart_pkg.sv
verilog/mem_bus_if.sv
verilog/cart_loader.sv
verilog/rom_fetch.sv
verilog/mem_arbiter.sv
verilog/cart_ram.sv
verilog/pad_mux.sv
verilog/pce_cart_top.sv
verification/tb_pce_cart.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cartridge front end testbench with Verilator

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
  echo "cannot enter project directory"
  exit $status
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f pce_cart_top.f --top-module tb_pce_cart -o tb_pce_cart
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/tb_pce_cart
status=$?
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit $status
fi

exit 0
